// File: Bender.yml
package:
  name: uart_apb

sources:
  - source/uart_pkg.sv
  - source/uart_apb_decode.sv
  - source/uart_rx.sv
  - source/uart_tx.sv
  - source/uart_result.sv
  - source/uart_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_uart_top.sv

// File: source/uart_apb_decode.sv
`timescale 1ns/1ns

module uart_apb_decode (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [uart_pkg::addr_width-1:0] paddr,
  input  uart_pkg::write_word_u           pwdata,
  input  logic                            tx_busy,
  output logic                            pready,
  output logic                            pslverr,
  output logic                            tx_start,
  output logic [uart_pkg::byte_width-1:0] tx_byte,
  output logic                            rx_read,
  output logic                            irq_enable,
  output logic [uart_pkg::sel_width-1:0]  read_sel
);

  logic access;
  logic hit_data;
  logic hit_status;
  logic hit_control;
  logic write_ok;
  logic read_ok;
  logic read_done;

  // access phase of a selected transfer
  assign access = psel & penable;

  assign hit_data    = (paddr == uart_pkg::addr_data);
  assign hit_status  = (paddr == uart_pkg::addr_status);
  assign hit_control = (paddr == uart_pkg::addr_control);

  // status is read only
  assign write_ok = hit_data | hit_control;
  assign read_ok  = hit_data | hit_status | hit_control;

  // only a data write can stall, and only while the serializer is busy
  assign pready  = ~(access & pwrite & hit_data & tx_busy);
  assign pslverr = access & (pwrite ? ~write_ok : ~read_ok);

  assign tx_start = access & pwrite & hit_data & ~tx_busy;
  assign tx_byte  = pwdata.tx.data;

  assign read_done = access & ~pwrite;
  assign rx_read   = read_done & hit_data;

  always_comb begin
    read_sel = '0;
    read_sel[uart_pkg::sel_data]    = read_done & hit_data;
    read_sel[uart_pkg::sel_status]  = read_done & hit_status;
    read_sel[uart_pkg::sel_control] = read_done & hit_control;
  end

  ////////////////////////////////////////////////////////////////////
  // control register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      irq_enable <= 1'b0;
    end else if (access && pwrite && hit_control) begin
      irq_enable <= pwdata.control.rx_irq_enable;
    end
  end

  // apb enable phase only inside a selected transfer
  penable_needs_psel: assert property (
    @(posedge clock) disable iff (!reset)
    penable |-> psel
  );

endmodule

// File: source/uart_pkg.sv
package uart_pkg;

  ////////////////////////////////////////////////////////////////////
  // bus and payload widths
  ////////////////////////////////////////////////////////////////////

  localparam int addr_width = 4;
  localparam int data_width = 32;
  localparam int byte_width = 8;

  // register offsets on the APB port
  localparam logic [addr_width-1:0] addr_data    = 4'h0;
  localparam logic [addr_width-1:0] addr_status  = 4'h4;
  localparam logic [addr_width-1:0] addr_control = 4'h8;

  // one-hot read select between decoder and read mux
  localparam int sel_width   = 3;
  localparam int sel_data    = 0;
  localparam int sel_status  = 1;
  localparam int sel_control = 2;

  ////////////////////////////////////////////////////////////////////
  // register words
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [data_width-byte_width-1:0] unused;
    logic [byte_width-1:0]            data;
  } tx_word_t;

  typedef struct packed {
    logic [data_width-2:0] reserved;
    logic                  rx_irq_enable;
  } control_word_t;

  // same write word, viewed by address
  typedef union packed {
    tx_word_t      tx;
    control_word_t control;
  } write_word_u;

  typedef struct packed {
    logic [data_width-4:0] zero;
    logic                  rx_overrun;
    logic                  rx_ready;
    logic                  tx_busy;
  } status_word_t;

endpackage

// File: source/uart_result.sv
`timescale 1ns/1ns

module uart_result (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [uart_pkg::sel_width-1:0]  read_sel,
  input  logic [uart_pkg::byte_width-1:0] rx_byte,
  input  logic                            rx_ready,
  input  logic                            rx_new,
  input  logic                            rx_read,
  input  logic                            tx_busy,
  input  logic                            irq_enable,
  output logic [uart_pkg::data_width-1:0] prdata,
  output logic                            irq
);

  uart_pkg::status_word_t status;
  logic                   overrun;
  logic                   ready_next;

  always_comb begin
    status            = '0;
    status.tx_busy    = tx_busy;
    status.rx_ready   = rx_ready;
    status.rx_overrun = overrun;
  end

  // read data, only during the access cycle of a read
  always_comb begin
    prdata = '0;
    if (read_sel[uart_pkg::sel_data]) begin
      prdata[uart_pkg::byte_width-1:0] = rx_byte;
    end else if (read_sel[uart_pkg::sel_status]) begin
      prdata = status;
    end else if (read_sel[uart_pkg::sel_control]) begin
      prdata[0] = irq_enable;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // overrun and interrupt
  ////////////////////////////////////////////////////////////////////

  // previous byte still unread when the next one lands
  always_ff @(posedge clock) begin
    if (!reset) begin
      overrun <= 1'b0;
    end else if (rx_new && rx_ready && !rx_read) begin
      overrun <= 1'b1;
    end else if (read_sel[uart_pkg::sel_status]) begin
      overrun <= 1'b0;
    end
  end

  // next value of rx_ready, so irq tracks it without extra lag
  assign ready_next = rx_new | (rx_ready & ~rx_read);

  always_ff @(posedge clock) begin
    if (!reset) begin
      irq <= 1'b0;
    end else begin
      irq <= ready_next & irq_enable;
    end
  end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
  parameter int clocks_per_bit = 8
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            rx,
  input  logic                            rx_read,
  output logic [uart_pkg::byte_width-1:0] rx_byte,
  output logic                            rx_ready,
  output logic                            rx_new
);

  localparam int count_width = $clog2(clocks_per_bit);
  localparam logic [count_width-1:0] full = count_width'(clocks_per_bit - 1);
  localparam logic [count_width-1:0] half = count_width'(clocks_per_bit / 2 - 1);

  // states idle, start, eight data bits and stop
  localparam logic [3:0] st_idle  = 4'd0;
  localparam logic [3:0] st_start = 4'd1;
  localparam logic [3:0] st_last  = 4'd9;
  localparam logic [3:0] st_stop  = 4'd10;

  logic                   rx_meta;
  logic                   rx_sync;
  logic [3:0]             state;
  logic [count_width-1:0] count;
  logic [8:0]             shift;
  logic                   tick;

  // line is asynchronous to clock
  always_ff @(posedge clock) begin
    if (!reset) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // half period to the start sample, full period after that
  assign tick   = (state == st_start) ? (count == half) : (count == full);
  assign rx_new = (state == st_stop) && tick;

  ////////////////////////////////////////////////////////////////////
  // bit sequencer
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_idle;
      count <= '0;
    end else if (state == st_idle) begin
      count <= '0;
      if (!rx_sync) begin
        state <= st_start;
      end
    end else if (tick) begin
      count <= '0;
      if (state == st_stop) begin
        state <= st_idle;
      end else if (state == st_start && rx_sync) begin
        // glitch rather than a start bit
        state <= st_idle;
      end else begin
        state <= state + 4'd1;
      end
    end else begin
      count <= count + 1'b1;
    end
  end

  // start bit ends up in shift[0], data lsb first above it
  always_ff @(posedge clock) begin
    if (tick && state >= st_start && state <= st_last) begin
      shift <= {rx_sync, shift[8:1]};
    end
  end

  always_ff @(posedge clock) begin
    if (rx_new) begin
      rx_byte <= shift[8:1];
    end
  end

  // a new byte wins over a read in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      rx_ready <= 1'b0;
    end else if (rx_new) begin
      rx_ready <= 1'b1;
    end else if (rx_read) begin
      rx_ready <= 1'b0;
    end
  end

  // stop sample hands over a byte and goes back to idle
  rx_new_ends_frame: assert property (
    @(posedge clock) disable iff (!reset)
    rx_new |=> (state == st_idle) && rx_ready
  );

endmodule

// File: source/uart_top.sv
`timescale 1ns/1ns

module uart_top #(
  parameter int clocks_per_bit = 8
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [uart_pkg::addr_width-1:0] paddr,
  input  logic [uart_pkg::data_width-1:0] pwdata,
  output logic [uart_pkg::data_width-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  logic                            rx,
  output logic                            tx,
  output logic                            irq
);

  logic                            tx_start;
  logic [uart_pkg::byte_width-1:0] tx_byte;
  logic                            tx_busy;
  logic                            rx_read;
  logic                            rx_ready;
  logic                            rx_new;
  logic [uart_pkg::byte_width-1:0] rx_byte;
  logic                            irq_enable;
  logic [uart_pkg::sel_width-1:0]  read_sel;

  uart_apb_decode i_decode (
    .clock      (clock),
    .reset      (reset),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .tx_busy    (tx_busy),
    .pready     (pready),
    .pslverr    (pslverr),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte),
    .rx_read    (rx_read),
    .irq_enable (irq_enable),
    .read_sel   (read_sel)
  );

  uart_rx #(.clocks_per_bit(clocks_per_bit)) i_rx (
    .clock    (clock),
    .reset    (reset),
    .rx       (rx),
    .rx_read  (rx_read),
    .rx_byte  (rx_byte),
    .rx_ready (rx_ready),
    .rx_new   (rx_new)
  );

  uart_tx #(.clocks_per_bit(clocks_per_bit)) i_tx (
    .clock    (clock),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_result i_result (
    .clock      (clock),
    .reset      (reset),
    .read_sel   (read_sel),
    .rx_byte    (rx_byte),
    .rx_ready   (rx_ready),
    .rx_new     (rx_new),
    .rx_read    (rx_read),
    .tx_busy    (tx_busy),
    .irq_enable (irq_enable),
    .prdata     (prdata),
    .irq        (irq)
  );

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
  parameter int clocks_per_bit = 8
) (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            tx_start,
  input  logic [uart_pkg::byte_width-1:0] tx_byte,
  output logic                            tx,
  output logic                            tx_busy
);

  localparam int count_width = $clog2(clocks_per_bit);
  localparam logic [count_width-1:0] full = count_width'(clocks_per_bit - 1);

  logic [9:0]             frame;
  logic [count_width-1:0] count;
  logic [3:0]             bit_index;
  logic                   tick;

  assign tick = tx_busy && (count == full);

  // line follows the low end of the frame, ones fill in behind it
  assign tx = frame[0];

  ////////////////////////////////////////////////////////////////////
  // serializer
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (!reset) begin
      frame     <= '1;
      count     <= '0;
      bit_index <= '0;
      tx_busy   <= 1'b0;
    end else if (!tx_busy) begin
      count     <= '0;
      bit_index <= '0;
      if (tx_start) begin
        // stop, data lsb first, start
        frame   <= {1'b1, tx_byte, 1'b0};
        tx_busy <= 1'b1;
      end
    end else if (tick) begin
      count     <= '0;
      frame     <= {1'b1, frame[9:1]};
      bit_index <= bit_index + 4'd1;
      if (bit_index == 4'd9) begin
        // end of stop bit
        tx_busy <= 1'b0;
      end
    end else begin
      count <= count + 1'b1;
    end
  end

  // idle line must be at mark level
  tx_idle_high: assert property (
    @(posedge clock) disable iff (!reset)
    !tx_busy |-> tx
  );

endmodule

// File: src.f
+incdir+verif
source/uart_pkg.sv
source/uart_apb_decode.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_result.sv
source/uart_top.sv
verif/tb_uart_top.sv

// File: verif/uart_tb_tasks.svh
////////////////////////////////////////////////////////////////////
// run control and compares
////////////////////////////////////////////////////////////////////

task automatic abort_run(input string msg);
  $display("%s", msg);
  $display("Verification failed");
  $fatal(1);
endtask

task automatic compare_status(input uart_pkg::status_word_t expected,
                              input uart_pkg::status_word_t actual);
  if (actual !== expected) begin
    abort_run($sformatf("[FAIL] %0t: status expected %h, got %h", $time, expected, actual));
  end
endtask

task automatic compare_byte(input logic [uart_pkg::byte_width-1:0] expected,
                            input logic [uart_pkg::byte_width-1:0] actual, input string what);
  if (actual !== expected) begin
    abort_run($sformatf("[FAIL] %0t: %s expected %h, got %h", $time, what, expected, actual));
  end
endtask

task automatic compare_error(input logic expected, input logic actual);
  if (actual !== expected) begin
    abort_run($sformatf("[FAIL] %0t: pslverr expected %b, got %b", $time, expected, actual));
  end
endtask

task automatic compare_level(input logic expected, input logic actual, input string what);
  if (actual !== expected) begin
    abort_run($sformatf("[FAIL] %0t: %s expected %b, got %b", $time, what, expected, actual));
  end
endtask

////////////////////////////////////////////////////////////////////
// apb master
////////////////////////////////////////////////////////////////////

task automatic apb_transfer(input logic write, input logic [uart_pkg::addr_width-1:0] addr,
                            input logic [uart_pkg::data_width-1:0] wdata,
                            output logic [uart_pkg::data_width-1:0] rdata,
                            output logic err, output int waits);
  @(negedge clock);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = write;
  paddr   = addr;
  pwdata  = wdata;
  @(negedge clock);
  penable = 1'b1;
  waits   = 0;
  // sample halfway to the rising edge
  #1;
  while (!pready && waits < access_timeout) begin
    @(negedge clock);
    #1;
    waits++;
  end
  if (!pready) begin
    abort_run("an APB transfer never got pready from the DUT");
  end
  rdata = prdata;
  err   = pslverr;
  @(negedge clock);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

////////////////////////////////////////////////////////////////////
// serial line
////////////////////////////////////////////////////////////////////

task automatic drive_frame(input logic [uart_pkg::byte_width-1:0] value);
  logic [9:0] bits;
  int         gap;
  bits = {1'b1, value, 1'b0};
  gap  = $urandom % 16;
  repeat (gap) @(negedge clock);
  for (int i = 0; i < 10; i++) begin
    @(negedge clock);
    rx = bits[i];
    repeat (clocks_per_bit - 1) @(negedge clock);
  end
endtask

// entered half a cycle into the start bit
task automatic capture_frame();
  logic [uart_pkg::byte_width-1:0] value;
  repeat (clocks_per_bit / 2) @(negedge clock);
  compare_level(1'b0, tx, "tx start bit");
  for (int i = 0; i < uart_pkg::byte_width; i++) begin
    repeat (clocks_per_bit) @(negedge clock);
    value[i] = tx;
  end
  repeat (clocks_per_bit) @(negedge clock);
  compare_level(1'b1, tx, "tx stop bit");
  // hand over only once the stop bit has ended
  repeat (clocks_per_bit / 2) @(negedge clock);
  tx_frames.push_back(value);
endtask

task automatic expect_frame(input logic [uart_pkg::byte_width-1:0] value);
  int cycles;
  cycles = 0;
  while (tx_frames.size() == 0 && cycles < frame_timeout) begin
    @(negedge clock);
    cycles++;
  end
  if (tx_frames.size() == 0) begin
    abort_run("no frame appeared on the tx line in time");
  end
  compare_byte(value, tx_frames.pop_front(), "tx frame");
endtask

task automatic wait_irq(input logic level);
  int cycles;
  cycles = 0;
  while (irq !== level && cycles < irq_timeout) begin
    @(negedge clock);
    cycles++;
  end
  if (irq !== level) begin
    abort_run("irq did not reach the expected level in time");
  end
endtask

// File: verif/tb_uart_top.sv
`timescale 1ns/1ns

module tb_uart_top;

  localparam int clocks_per_bit = 8;
  localparam int access_timeout = 200;
  localparam int frame_timeout  = 400;
  localparam int irq_timeout    = 200;
  localparam int run_limit      = 20000;

  logic                            clock;
  logic                            reset;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [uart_pkg::addr_width-1:0] paddr;
  logic [uart_pkg::data_width-1:0] pwdata;
  logic [uart_pkg::data_width-1:0] prdata;
  logic                            pready;
  logic                            pslverr;
  logic                            rx;
  logic                            tx;
  logic                            irq;

  // bytes decoded from tx in arrival order
  logic [uart_pkg::byte_width-1:0] tx_frames[$];

  `include "uart_tb_tasks.svh"

  uart_top #(.clocks_per_bit(clocks_per_bit)) i_uart_top (
    .clock   (clock),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rx      (rx),
    .tx      (tx),
    .irq     (irq)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // tx monitor
  always @(negedge clock) begin
    if (reset && tx === 1'b0) begin
      capture_frame();
    end
  end

  initial begin
    repeat (run_limit) @(posedge clock);
    abort_run("the run did not finish within its cycle limit");
  end

  initial begin
    int                              fd;
    int                              code;
    int                              fields;
    int                              line_no;
    int                              ops_run;
    int                              waits;
    string                           line;
    string                           op;
    logic [uart_pkg::data_width-1:0] addr;
    logic [uart_pkg::data_width-1:0] value;
    logic [uart_pkg::data_width-1:0] err_exp;
    logic [uart_pkg::data_width-1:0] stall_exp;
    logic [uart_pkg::data_width-1:0] rdata;
    logic                            err;
    void'($urandom(20));
    reset   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    rx      = 1'b1;
    line_no = 0;
    ops_run = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    @(negedge clock);
    compare_level(1'b1, tx, "tx after reset");
    compare_level(1'b0, irq, "irq after reset");

    fd = $fopen("verif/uart_input.txt", "r");
    if (fd == 0) begin
      abort_run("the stimulus file verif/uart_input.txt could not be opened");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      line_no++;
      if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h", op, addr, value, err_exp, stall_exp);
        if (fields != 5) begin
          abort_run($sformatf("line %0d of the stimulus file could not be parsed", line_no));
        end
        case (op)
          "apb_write", "apb_read": begin
            apb_transfer(op == "apb_write", addr[uart_pkg::addr_width-1:0], value,
                         rdata, err, waits);
            compare_error(err_exp[0], err);
            compare_level(stall_exp[0], waits > 0, "wait states");
            if (op == "apb_read" && addr == uart_pkg::addr_status) begin
              compare_status(value, rdata);
            end else if (op == "apb_read") begin
              compare_byte(value[uart_pkg::byte_width-1:0],
                           rdata[uart_pkg::byte_width-1:0], "read data");
            end
          end
          "send_serial":   drive_frame(value[uart_pkg::byte_width-1:0]);
          "expect_serial": expect_frame(value[uart_pkg::byte_width-1:0]);
          "wait_irq":      wait_irq(value[0]);
          "check_irq": begin
            @(negedge clock);
            compare_level(value[0], irq, "irq");
          end
          default: abort_run($sformatf("unknown operation %s in line %0d", op, line_no));
        endcase
        ops_run++;
      end
    end
    $fclose(fd);

    if (ops_run > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("the stimulus file held no operations");
    end
  end

endmodule

// File: verif/uart_input.txt
# columns: operation, address, data or expected value, expected pslverr, expected stall
# all fields hex, fields an operation does not use are 0
apb_read      4 00 0 0
apb_read      8 00 0 0
# transmit, second write stalls behind the first frame
apb_write     0 a5 0 0
apb_read      4 01 0 0
apb_write     0 3c 0 1
expect_serial 0 a5 0 0
expect_serial 0 3c 0 0
apb_read      4 00 0 0
# receive with the interrupt disabled, then enabled
send_serial   0 5a 0 0
apb_read      4 02 0 0
check_irq     0 00 0 0
apb_read      0 5a 0 0
apb_read      4 00 0 0
apb_write     8 01 0 0
apb_read      8 01 0 0
send_serial   0 c3 0 0
wait_irq      0 01 0 0
apb_read      0 c3 0 0
check_irq     0 00 0 0
# overrun
send_serial   0 11 0 0
send_serial   0 e7 0 0
apb_read      4 06 0 0
apb_read      0 e7 0 0
apb_read      4 00 0 0
# error responses
apb_write     4 07 1 0
apb_read      4 00 0 0
apb_write     c 00 1 0
apb_read      8 01 0 0
apb_read      c 00 1 0
apb_write     2 ff 1 0
apb_read      4 00 0 0
